// File: hdl/avmm_pkg.sv
/*
 * Avalon-MM bus widths, opcode and the command, request and response structs.
 * Imported by every RTL block that moves commands, requests or responses.
 */
package avmm_pkg;

    // Word address, so 1024 words are reachable
    localparam int ADDR_WIDTH = 10;

    // One data word per beat
    localparam int DATA_WIDTH = 32;

    // Burstcount field width. Bursts run from 1 to 8 beats
    localparam int BURST_WIDTH = 4;

    // Host command opcode
    typedef enum logic [0:0]
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } avmm_op_e;

    // A single host command, handed over with a one-cycle cmd_valid pulse.
    // For a write burst only the first data word travels here and the rest
    // arrive on the separate wdata port, one word per beat
    typedef struct packed
    {
        avmm_op_e               op;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [BURST_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]  data;
    } avmm_cmd_t;

    // Master to slave request. Read and write are plain strobes, and a write
    // burst repeats addr and burstcount of the burst base on every beat
    typedef struct packed
    {
        logic                   read;
        logic                   write;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [BURST_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]  writedata;
    } avmm_req_t;

    // Slave to master response, one struct per read beat
    typedef struct packed
    {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
    } avmm_rsp_t;

endpackage

// File: hdl/mem_cfg_pkg.sv
/*
 * Configuration of the memory subsystem: slice depth, waitrequest allowance,
 * SRAM and FIFO sizes, and the state encodings of the issuer and slave.
 */
package mem_cfg_pkg;

    // Request and response register stages inside the slice
    localparam int N_REG_STAGES = 2;

    // Delay of waitrequest on its way back to the sender
    localparam int N_WAITREQUEST_STAGES = N_REG_STAGES;

    // Requests that may still reach the slave after it raises waitrequest
    localparam int WAIT_ALLOWANCE = N_REG_STAGES + N_WAITREQUEST_STAGES;

    // SRAM size in words
    localparam int MEM_WORDS = 1024;

    // Slave request FIFO, which must be deeper than the allowance
    localparam int REQ_FIFO_DEPTH = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(REQ_FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(REQ_FIFO_DEPTH + 1);

    // Slave read engine
    typedef enum logic [0:0]
    {
        SL_IDLE       = 1'b0,
        SL_READ_BURST = 1'b1
    } slave_state_e;

    // Command issuer
    typedef enum logic [1:0]
    {
        IS_IDLE        = 2'd0,
        IS_WRITE_BURST = 2'd1,
        IS_READ        = 2'd2
    } issuer_state_e;

endpackage

// File: hdl/avmm_cmd_issuer.sv
/*
 * Host side producer. Latches one command at a time and turns it into a single
 * read request or into one write beat per cycle, honouring waitrequest.
 */
module avmm_cmd_issuer
    import avmm_pkg::*;
    import mem_cfg_pkg::*;
(
    input  logic                  mem_slave,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  avmm_cmd_t             cmd,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  wdata_valid,
    output logic                  cmd_ready,
    output logic                  wdata_ready,
    output avmm_req_t             req_m,
    input  logic                  waitrequest_m
);

    issuer_state_e          state;
    avmm_cmd_t              cmd_q;
    logic [BURST_WIDTH-1:0] beat_cnt;
    logic                   issued;
    logic                   last_beat;

    // A new command is taken only between commands
    assign cmd_ready = (state == IS_IDLE);

    // Beat 0 of a write takes its data from the command, later beats from wdata
    always_comb
    begin
        req_m            = '0;
        req_m.addr       = cmd_q.addr;
        req_m.burstcount = cmd_q.burstcount;
        req_m.writedata  = (beat_cnt == '0) ? cmd_q.data : wdata;
        wdata_ready      = 1'b0;
        case (state)
            IS_READ:
            begin
                req_m.read = 1'b1;
            end
            IS_WRITE_BURST:
            begin
                if (beat_cnt == '0)
                begin
                    req_m.write = 1'b1;
                end
                else
                begin
                    // A wdata word is consumed only when the beat really goes out
                    req_m.write = wdata_valid;
                    wdata_ready = !waitrequest_m;
                end
            end
            default:
            begin
                req_m.read = 1'b0;
            end
        endcase
    end

    // The slice drops strobes that meet waitrequest, so a request counts as
    // issued only in a cycle with waitrequest low
    assign issued    = (req_m.read || req_m.write) && !waitrequest_m;
    assign last_beat = (beat_cnt == cmd_q.burstcount - 1'b1);

    // The command is latched as it is accepted
    always_ff @(posedge mem_slave)
    begin
        if (cmd_ready && cmd_valid)
        begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            state    <= IS_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            case (state)
                IS_IDLE:
                begin
                    beat_cnt <= '0;
                    if (cmd_valid)
                    begin
                        state <= (cmd.op == OP_READ) ? IS_READ : IS_WRITE_BURST;
                    end
                end
                IS_READ:
                begin
                    // The whole read burst is one request
                    if (issued)
                    begin
                        state <= IS_IDLE;
                    end
                end
                IS_WRITE_BURST:
                begin
                    if (issued)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat)
                        begin
                            state <= IS_IDLE;
                        end
                    end
                end
                default:
                begin
                    state <= IS_IDLE;
                end
            endcase
        end
    end

    // Read and write are never requested together
    assert property (@(posedge mem_slave) disable iff (!rst_n)
        !(req_m.read && req_m.write));

endmodule

// File: hdl/avmm_reg_pipe.sv
/*
 * Avalon-MM register slice. Requests and responses pass N register stages and
 * waitrequest returns through its own shift register, acting as almost-full.
 */
module avmm_reg_pipe
    import avmm_pkg::*;
    import mem_cfg_pkg::*;
(
    input  logic      mem_slave,
    input  logic      rst_n,
    input  avmm_req_t req_m,
    output logic      waitrequest_m,
    output avmm_rsp_t rsp_m,
    output avmm_req_t req_s,
    input  logic      waitrequest_s,
    input  avmm_rsp_t rsp_s
);

    // Request stage 0 is nearest the master, the last stage drives the slave
    avmm_req_t req_stage [N_REG_STAGES];

    // Response stage 0 is nearest the slave, the last stage drives the master
    avmm_rsp_t rsp_stage [N_REG_STAGES];

    // Bit 0 is the slave's live waitrequest, the top bit is what the master sees
    logic [N_WAITREQUEST_STAGES:0] wait_pipe;

    avmm_req_t req_in;

    // The slice never stalls on its own.
    // Strobes that arrive while the delayed waitrequest is high are dropped,
    // and the master is expected to hold them until waitrequest falls
    always_comb
    begin
        req_in       = req_m;
        req_in.read  = req_m.read && !waitrequest_m;
        req_in.write = req_m.write && !waitrequest_m;
    end

    // Request pipeline
    always_ff @(posedge mem_slave)
    begin
        req_stage[0] <= req_in;
        for (int s = 1; s < N_REG_STAGES; s++)
        begin
            req_stage[s] <= req_stage[s-1];
        end

        // Only the strobes need clearing, address and data follow them
        if (!rst_n)
        begin
            for (int s = 0; s < N_REG_STAGES; s++)
            begin
                req_stage[s].read  <= 1'b0;
                req_stage[s].write <= 1'b0;
            end
        end
    end

    // Response pipeline, same depth as the requests
    always_ff @(posedge mem_slave)
    begin
        rsp_stage[0] <= rsp_s;
        for (int s = 1; s < N_REG_STAGES; s++)
        begin
            rsp_stage[s] <= rsp_stage[s-1];
        end

        if (!rst_n)
        begin
            for (int s = 0; s < N_REG_STAGES; s++)
            begin
                rsp_stage[s].readdatavalid <= 1'b0;
            end
        end
    end

    // Waitrequest shift register, cleared to low so the master may start at once
    assign wait_pipe[0] = waitrequest_s;

    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            wait_pipe[N_WAITREQUEST_STAGES:1] <= '0;
        end
        else
        begin
            wait_pipe[N_WAITREQUEST_STAGES:1] <= wait_pipe[N_WAITREQUEST_STAGES-1:0];
        end
    end

    assign waitrequest_m = wait_pipe[N_WAITREQUEST_STAGES];
    assign req_s         = req_stage[N_REG_STAGES-1];
    assign rsp_m         = rsp_stage[N_REG_STAGES-1];

    // Nothing enters the first stage in a cycle where the master saw waitrequest
    assert property (@(posedge mem_slave) disable iff (!rst_n)
        waitrequest_m |=> !(req_stage[0].read || req_stage[0].write));

endmodule

// File: hdl/avmm_sram_slave.sv
/*
 * On-chip SRAM slave. Requests queue in a FIFO whose free space drives an
 * almost-full waitrequest, and read bursts return one word per cycle.
 */
module avmm_sram_slave
    import avmm_pkg::*;
    import mem_cfg_pkg::*;
(
    input  logic      mem_slave,
    input  logic      rst_n,
    input  avmm_req_t req_s,
    output logic      waitrequest_s,
    output avmm_rsp_t rsp_s,
    input  logic      mem_hold
);

    avmm_req_t                fifo_mem [REQ_FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] fifo_count;
    logic [FIFO_CNT_WIDTH-1:0] fifo_free;
    logic                      push;
    logic                      pop;

    logic [DATA_WIDTH-1:0]  mem [MEM_WORDS];
    avmm_req_t              exec_q;
    slave_state_e           state;
    logic [ADDR_WIDTH-1:0]  rd_addr;
    logic [BURST_WIDTH-1:0] rd_left;
    logic [BURST_WIDTH-1:0] wr_beat;
    logic [ADDR_WIDTH-1:0]  wr_addr;
    logic [ADDR_WIDTH-1:0]  mem_rd_addr;
    logic                   rsp_valid_q;
    logic [DATA_WIDTH-1:0]  rsp_data_q;

    // Every strobe that reaches the slave is queued, there is no refusal here
    assign push      = req_s.read || req_s.write;
    assign fifo_free = FIFO_CNT_WIDTH'(REQ_FIFO_DEPTH) - fifo_count;

    // Raised early enough that requests still in flight fit into the FIFO
    assign waitrequest_s = (fifo_free <= WAIT_ALLOWANCE);

    // No pop while a read occupies the execute stage or the burst engine,
    // so SRAM sees at most one access per cycle
    assign pop = (fifo_count != '0) && !mem_hold && (state == SL_IDLE) && !exec_q.read;

    always_ff @(posedge mem_slave)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= req_s;
        end
    end

    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end
        else
        begin
            wr_ptr     <= wr_ptr + FIFO_PTR_WIDTH'(push);
            rd_ptr     <= rd_ptr + FIFO_PTR_WIDTH'(pop);
            fifo_count <= fifo_count + FIFO_CNT_WIDTH'(push) - FIFO_CNT_WIDTH'(pop);
        end
    end

    // Execute stage, one cycle after the pop
    always_ff @(posedge mem_slave)
    begin
        exec_q <= fifo_mem[rd_ptr];
        if (!rst_n || !pop)
        begin
            exec_q.read  <= 1'b0;
            exec_q.write <= 1'b0;
        end
    end

    // Write beats land at the burst base plus their index in the burst
    assign wr_addr = exec_q.addr + ADDR_WIDTH'(wr_beat);

    // Beat 0 of a read comes from the execute stage, later beats from the engine
    assign mem_rd_addr = (state == SL_READ_BURST) ? rd_addr : exec_q.addr;

    always_ff @(posedge mem_slave)
    begin
        if (exec_q.write)
        begin
            mem[wr_addr] <= exec_q.writedata;
        end
        rsp_data_q <= mem[mem_rd_addr];
    end

    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            state       <= SL_IDLE;
            rd_addr     <= '0;
            rd_left     <= '0;
            wr_beat     <= '0;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= exec_q.read || (state == SL_READ_BURST);

            if (exec_q.write)
            begin
                wr_beat <= (wr_beat == exec_q.burstcount - 1'b1) ? '0 : wr_beat + 1'b1;
            end

            case (state)
                SL_IDLE:
                begin
                    if (exec_q.read)
                    begin
                        rd_addr <= exec_q.addr + 1'b1;
                        rd_left <= exec_q.burstcount - 1'b1;
                        if (exec_q.burstcount > 1)
                        begin
                            state <= SL_READ_BURST;
                        end
                    end
                end
                SL_READ_BURST:
                begin
                    rd_addr <= rd_addr + 1'b1;
                    rd_left <= rd_left - 1'b1;
                    if (rd_left == 1)
                    begin
                        state <= SL_IDLE;
                    end
                end
                default:
                begin
                    state <= SL_IDLE;
                end
            endcase
        end
    end

    assign rsp_s.readdatavalid = rsp_valid_q;
    assign rsp_s.readdata      = rsp_data_q;

    // The allowance covers everything in flight, so a full FIFO is never pushed
    assert property (@(posedge mem_slave) disable iff (!rst_n)
        push |-> (fifo_count != FIFO_CNT_WIDTH'(REQ_FIFO_DEPTH)));

endmodule

// File: hdl/avmm_mem_top.sv
/*
 * Memory subsystem top level. Host commands go through the issuer and the
 * register slice to the SRAM slave, read data returns on rsp.
 */
module avmm_mem_top
    import avmm_pkg::*;
(
    input  logic                  mem_slave,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  avmm_cmd_t             cmd,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  wdata_valid,
    input  logic                  mem_hold,
    output logic                  cmd_ready,
    output logic                  wdata_ready,
    output avmm_rsp_t             rsp
);

    // Issuer side of the slice
    avmm_req_t req_m;
    logic      waitrequest_m;

    // Slave side of the slice
    avmm_req_t req_s;
    logic      waitrequest_s;
    avmm_rsp_t rsp_s;

    avmm_cmd_issuer i_issuer (
        .mem_slave     (mem_slave),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .wdata         (wdata),
        .wdata_valid   (wdata_valid),
        .cmd_ready     (cmd_ready),
        .wdata_ready   (wdata_ready),
        .req_m         (req_m),
        .waitrequest_m (waitrequest_m)
    );

    avmm_reg_pipe i_reg_pipe (
        .mem_slave     (mem_slave),
        .rst_n         (rst_n),
        .req_m         (req_m),
        .waitrequest_m (waitrequest_m),
        .rsp_m         (rsp),
        .req_s         (req_s),
        .waitrequest_s (waitrequest_s),
        .rsp_s         (rsp_s)
    );

    avmm_sram_slave i_sram (
        .mem_slave     (mem_slave),
        .rst_n         (rst_n),
        .req_s         (req_s),
        .waitrequest_s (waitrequest_s),
        .rsp_s         (rsp_s),
        .mem_hold      (mem_hold)
    );

endmodule

// File: tests/avmm_mem_checks.svh
/*
 * Result counters, typed compare tasks and the xorshift generator for the
 * memory subsystem testbench. Included inside the testbench module.
 */
`ifndef AVMM_MEM_CHECKS_SVH
`define AVMM_MEM_CHECKS_SVH

    // Totals over the whole run
    int          check_count = 0;
    int          error_count = 0;

    // Totals at the start of the running test, for the per-test line
    int          test_checks_start = 0;
    int          test_errors_start = 0;
    string       cur_test = "none";

    // Stimulus generator state, seeded once
    logic [31:0] rng_state = 32'd61;

    // Plain 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic start_test(input string name);
        cur_test          = name;
        test_checks_start = check_count;
        test_errors_start = error_count;
    endtask

    task automatic finish_test();
        $display("test %s done: %0d checks, %0d errors", cur_test,
                 check_count - test_checks_start, error_count - test_errors_start);
    endtask

    // One read beat against the beat the model predicts
    task automatic compare_rsp(input avmm_rsp_t exp, input avmm_rsp_t act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error %s: rsp expected valid %0b data %h, actual valid %0b data %h",
                     cur_test, exp.readdatavalid, exp.readdata,
                     act.readdatavalid, act.readdata);
        end
    endtask

    // A single control output against its expected level
    task automatic compare_level(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("error %s: %s expected %0b, actual %0b", cur_test, what, exp, act);
        end
    endtask

    // Failures that have no single expected value
    task automatic report_failure(input string what);
        check_count++;
        error_count++;
        $display("test %s failed: %s", cur_test, what);
    endtask

`endif

// File: tests/avmm_mem_tb.sv
/*
 * Testbench for the Avalon-MM memory subsystem. Runs directed tests on
 * avmm_mem_top and checks every read beat against a reference memory model.
 */
module avmm_mem_tb
    import avmm_pkg::*;
    import mem_cfg_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int QUIET_CYCLES  = 20;
    localparam int HOLD_CYCLES   = 30;
    localparam int DRAIN_LIMIT   = 2000;
    localparam int RANDOM_CMDS   = 200;
    localparam int RANDOM_WINDOW = 64;

    // Beats of all tests, with every random command counted at full length
    localparam int PLANNED_BEATS   = 2 + 16 + 16 + RANDOM_CMDS * 8;
    localparam int WATCHDOG_CYCLES = PLANNED_BEATS * 50 + RESET_CYCLES + 5000;

    logic                  mem_slave;
    logic                  rst_n;
    logic                  cmd_valid;
    avmm_cmd_t             cmd;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  wdata_valid;
    logic                  mem_hold;
    logic                  cmd_ready;
    logic                  wdata_ready;
    avmm_rsp_t             rsp;

    // Reference memory, holding only the words that have been written
    logic [DATA_WIDTH-1:0] ref_mem [int];

    // Read beats still owed by the DUT, oldest first
    avmm_rsp_t             exp_q [$];

    // Data words of the write burst being issued
    logic [DATA_WIDTH-1:0] burst_words [8];

    // Random gaps in wdata_valid and random mem_hold, used by the random test
    logic                  wdata_gaps;
    logic                  hold_random;
    logic [31:0]           hold_rng;

    `include "avmm_mem_checks.svh"

    avmm_mem_top i_dut (
        .mem_slave   (mem_slave),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .wdata       (wdata),
        .wdata_valid (wdata_valid),
        .mem_hold    (mem_hold),
        .cmd_ready   (cmd_ready),
        .wdata_ready (wdata_ready),
        .rsp         (rsp)
    );

    initial
    begin
        mem_slave = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) mem_slave = ~mem_slave;
        end
    end

    // Word address of beat i in a burst, wrapping at the top of the SRAM
    function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr, input int i);
        return (int'(addr) + i) % MEM_WORDS;
    endfunction

    function automatic logic range_written(input logic [ADDR_WIDTH-1:0] addr, input int len);
        for (int i = 0; i < len; i++)
        begin
            if (!ref_mem.exists(word_index(addr, i)))
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Responses are sampled on the falling edge, half a cycle after rsp changes
    always @(negedge mem_slave)
    begin
        if (rst_n && rsp.readdatavalid)
        begin
            if (exp_q.size() == 0)
            begin
                report_failure("a read beat arrived with no read outstanding");
            end
            else
            begin
                compare_rsp(exp_q.pop_front(), rsp);
            end
        end
    end

    // Word k of the burst is offered on wdata until the issuer takes it
    task automatic drive_wdata(input int k, input int len);
        if (k < len)
        begin
            wdata       = burst_words[k];
            wdata_valid = wdata_gaps ? (next_rand() % 4 != 0) : 1'b1;
        end
        else
        begin
            wdata_valid = 1'b0;
        end
    endtask

    // Hands one command to the DUT and feeds its write data.
    // Returns once cmd_ready is back, i.e. the whole command has been issued
    task automatic issue_cmd(input avmm_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                             input int len);
        int        k;
        logic      done;
        avmm_rsp_t beat;
        k    = 1;
        done = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            if (op == OP_WRITE)
            begin
                ref_mem[word_index(addr, i)] = burst_words[i];
            end
            else
            begin
                beat.readdatavalid = 1'b1;
                beat.readdata      = ref_mem[word_index(addr, i)];
                exp_q.push_back(beat);
            end
        end
        do
        begin
            @(negedge mem_slave);
        end
        while (!cmd_ready);
        @(posedge mem_slave);
        #DRIVE_DELAY;
        cmd_valid      = 1'b1;
        cmd.op         = op;
        cmd.addr       = addr;
        cmd.burstcount = BURST_WIDTH'(len);
        cmd.data       = burst_words[0];
        if (op == OP_WRITE)
        begin
            drive_wdata(k, len);
        end
        @(posedge mem_slave);
        #DRIVE_DELAY;
        cmd_valid = 1'b0;
        while (!done)
        begin
            @(negedge mem_slave);
            if (cmd_ready)
            begin
                done = 1'b1;
            end
            else
            begin
                // A word is taken in a cycle where valid and ready are both high
                if (wdata_valid && wdata_ready)
                begin
                    k++;
                end
                @(posedge mem_slave);
                #DRIVE_DELAY;
                if (op == OP_WRITE)
                begin
                    drive_wdata(k, len);
                end
            end
        end
        if (op == OP_WRITE && k != len)
        begin
            report_failure($sformatf("write burst of %0d beats took %0d wdata words",
                                     len, k - 1));
        end
    endtask

    // Waits until every owed beat is in, then watches a quiet window for extra beats
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT)
        begin
            @(negedge mem_slave);
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            report_failure($sformatf("%0d read beats never arrived", exp_q.size()));
            exp_q.delete();
        end
        repeat (QUIET_CYCLES) @(negedge mem_slave);
    endtask

    // Keeps the held read command pending for a while, then lets the slave drain
    task automatic hold_and_release();
        do
        begin
            @(negedge mem_slave);
        end
        while (cmd_ready);
        repeat (HOLD_CYCLES)
        begin
            @(negedge mem_slave);
            compare_level("cmd_ready while held", 1'b0, cmd_ready);
        end
        @(posedge mem_slave);
        #DRIVE_DELAY;
        mem_hold = 1'b0;
    endtask

    task automatic toggle_hold();
        while (hold_random)
        begin
            @(posedge mem_slave);
            #DRIVE_DELAY;
            hold_rng = xorshift32(hold_rng);
            mem_hold = (hold_rng[1:0] == 2'b00);
        end
        mem_hold = 1'b0;
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        @(negedge mem_slave);
        compare_level("cmd_ready", 1'b1, cmd_ready);
        compare_level("wdata_ready", 1'b0, wdata_ready);
        compare_level("rsp.readdatavalid", 1'b0, rsp.readdatavalid);
        finish_test();
    endtask

    task automatic test_single_write_read();
        start_test("single_write_read");
        burst_words[0] = next_rand();
        issue_cmd(OP_WRITE, 10'd5, 1);
        issue_cmd(OP_READ, 10'd5, 1);
        wait_drain();
        finish_test();
    endtask

    task automatic test_burst_write_read();
        start_test("burst_write_read");
        for (int i = 0; i < 8; i++)
        begin
            burst_words[i] = next_rand();
        end
        issue_cmd(OP_WRITE, 10'd16, 8);
        issue_cmd(OP_READ, 10'd16, 8);
        wait_drain();
        finish_test();
    endtask

    // The burst fills the FIFO while the slave is held, so the read stalls.
    // The burst also wraps from the top of the SRAM to address 0
    task automatic test_back_pressure();
        start_test("back_pressure");
        for (int i = 0; i < 8; i++)
        begin
            burst_words[i] = next_rand();
        end
        @(posedge mem_slave);
        #DRIVE_DELAY;
        mem_hold = 1'b1;
        issue_cmd(OP_WRITE, 10'h3FC, 8);
        fork
            issue_cmd(OP_READ, 10'h3FC, 8);
            hold_and_release();
        join
        wait_drain();
        finish_test();
    endtask

    task automatic test_random_traffic();
        logic [31:0]           r;
        avmm_op_e              op;
        logic [ADDR_WIDTH-1:0] addr;
        int                    len;
        start_test("random_traffic");
        wdata_gaps  = 1'b1;
        hold_rng    = next_rand();
        hold_random = 1'b1;
        fork
            toggle_hold();
            begin
                for (int n = 0; n < RANDOM_CMDS; n++)
                begin
                    r    = next_rand();
                    op   = r[0] ? OP_WRITE : OP_READ;
                    len  = int'(r[3:1]) + 1;
                    addr = ADDR_WIDTH'(r[15:8] % RANDOM_WINDOW);
                    // A read of words never written has no defined data, so write them
                    if (op == OP_READ && !range_written(addr, len))
                    begin
                        op = OP_WRITE;
                    end
                    if (op == OP_WRITE)
                    begin
                        for (int i = 0; i < len; i++)
                        begin
                            burst_words[i] = next_rand();
                        end
                    end
                    issue_cmd(op, addr, len);
                end
                hold_random = 1'b0;
            end
        join
        wdata_gaps = 1'b0;
        wait_drain();
        finish_test();
    endtask

    initial
    begin
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        wdata       = '0;
        wdata_valid = 1'b0;
        mem_hold    = 1'b0;
        wdata_gaps  = 1'b0;
        hold_random = 1'b0;
        hold_rng    = '0;
        repeat (RESET_CYCLES) @(posedge mem_slave);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        test_reset_state();
        test_single_write_read();
        test_burst_write_read();
        test_back_pressure();
        test_random_traffic();
        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Ends a run that stalls, for example on a lost request
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge mem_slave);
        $display("timeout after %0d cycles, test %s did not complete", WATCHDOG_CYCLES, cur_test);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+tests
hdl/avmm_pkg.sv
hdl/mem_cfg_pkg.sv
hdl/avmm_cmd_issuer.sv
hdl/avmm_reg_pipe.sv
hdl/avmm_sram_slave.sv
hdl/avmm_mem_top.sv
tests/avmm_mem_tb.sv

// File: Bender.yml
package:
  name: avmm_mem

sources:
  - files:
      - hdl/avmm_pkg.sv
      - hdl/mem_cfg_pkg.sv
      - hdl/avmm_cmd_issuer.sv
      - hdl/avmm_reg_pipe.sv
      - hdl/avmm_sram_slave.sv
      - hdl/avmm_mem_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/avmm_mem_tb.sv
